// ==== logic/ahb_gpio_pkg.sv ====
package ahb_gpio_pkg;

    // Transfer types with bit 1 marking an active transfer
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // Address bits 31:28
    localparam logic [3:0] GPIO_REGION = 4'h4;
    localparam logic [3:0] SRAM_REGION = 4'h2;

    // Register index from address bits 3:2
    localparam logic [1:0] GPIO_OFS_IN  = 2'd0;
    localparam logic [1:0] GPIO_OFS_ENA = 2'd1;
    localparam logic [1:0] GPIO_OFS_DAT = 2'd2;

    function automatic logic [3:0] byte_lanes(input logic [1:0] addr, input logic [2:0] size);
        logic [3:0] lanes;
        lanes = 4'b0000;
        case (size)
            HSIZE_WORD: lanes = (addr == 2'b00) ? 4'b1111 : 4'b0000;
            HSIZE_HALF: lanes = (addr == 2'b00) ? 4'b0011 : (addr == 2'b10) ? 4'b1100 : 4'b0000;
            HSIZE_BYTE: lanes = 4'b0001 << addr;
            default:    lanes = 4'b0000;
        endcase
        return lanes;
    endfunction

endpackage

// ==== logic/ahb_decoder.sv ====
`timescale 1ns/1ps

module ahb_decoder (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic [31:0] i_haddr,
    input  logic [1:0]  i_htrans,
    input  logic        i_hready,
    input  logic [31:0] i_gpio_rdata,
    input  logic        i_gpio_readyout,
    input  logic [31:0] i_sram_rdata,
    input  logic        i_sram_readyout,
    output logic        o_gpio_sel,
    output logic        o_sram_sel,
    output logic [31:0] o_hrdata,
    output logic        o_hready,
    output logic        o_hresp
);

    logic gpio_dp_q;
    logic sram_dp_q;

    assign o_gpio_sel = (i_haddr[31:28] == ahb_gpio_pkg::GPIO_REGION);
    assign o_sram_sel = (i_haddr[31:28] == ahb_gpio_pkg::SRAM_REGION);

    // Owner of the data phase
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            gpio_dp_q <= 1'b0;
            sram_dp_q <= 1'b0;
        end
        else if (i_hready)
        begin
            gpio_dp_q <= o_gpio_sel & i_htrans[1];
            sram_dp_q <= o_sram_sel & i_htrans[1];
        end
    end

    // Zero data and ready high when unmapped or idle
    assign o_hrdata = gpio_dp_q ? i_gpio_rdata :
                      sram_dp_q ? i_sram_rdata : 32'h0000_0000;
    assign o_hready = gpio_dp_q ? i_gpio_readyout :
                      sram_dp_q ? i_sram_readyout : 1'b1;

    assign o_hresp = 1'b0;

endmodule

// ==== logic/gpio_in_sync.sv ====
`timescale 1ns/1ps

module gpio_in_sync #(
    parameter int NUM_PORTS = 4
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic [NUM_PORTS*32-1:0] i_pins,
    output logic [NUM_PORTS*32-1:0] o_pins_sync
);

    logic [NUM_PORTS*32-1:0] stage1_q;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            stage1_q    <= '0;
            o_pins_sync <= '0;
        end
        else
        begin
            stage1_q    <= i_pins;
            o_pins_sync <= stage1_q;
        end
    end

endmodule

// ==== logic/ahb_gpio.sv ====
`timescale 1ns/1ps

module ahb_gpio #(
    parameter int NUM_PORTS = 4
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic                    i_hsel,
    input  logic [31:0]             i_haddr,
    input  logic [1:0]              i_htrans,
    input  logic [2:0]              i_hsize,
    input  logic                    i_hwrite,
    input  logic [31:0]             i_hwdata,
    input  logic                    i_hready,
    input  logic [NUM_PORTS*32-1:0] i_gpio_in,
    output logic [31:0]             o_hrdata,
    output logic                    o_hreadyout,
    output logic [NUM_PORTS*32-1:0] o_gpio_ena,
    output logic [NUM_PORTS*32-1:0] o_gpio_dat
);

    logic        access;
    logic        wr_q;
    logic        rd_q;
    logic [3:0]  group_q;
    logic [1:0]  index_q;
    logic [3:0]  lanes_q;
    logic [31:0] in_sel;
    logic [31:0] ena_sel;
    logic [31:0] dat_sel;
    logic [31:0] ena_q [NUM_PORTS];
    logic [31:0] dat_q [NUM_PORTS];

    assign access      = i_hsel & i_htrans[1] & i_hready;
    assign o_hreadyout = 1'b1;

    // Address phase capture
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            wr_q    <= 1'b0;
            rd_q    <= 1'b0;
            group_q <= 4'h0;
            index_q <= 2'd0;
            lanes_q <= 4'h0;
        end
        else if (i_hready)
        begin
            wr_q <= access & i_hwrite;
            rd_q <= access & ~i_hwrite;
            if (access)
            begin
                group_q <= i_haddr[7:4];
                index_q <= i_haddr[3:2];
                lanes_q <= ahb_gpio_pkg::byte_lanes(i_haddr[1:0], i_hsize);
            end
        end
    end

    // Lane merge at the end of the data phase
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            for (int g = 0; g < NUM_PORTS; g++)
            begin
                ena_q[g] <= 32'h0;
                dat_q[g] <= 32'h0;
            end
        end
        else if (wr_q && i_hready)
        begin
            for (int g = 0; g < NUM_PORTS; g++)
            begin
                if (int'(group_q) == g)
                begin
                    for (int b = 0; b < 4; b++)
                    begin
                        if (lanes_q[b] && index_q == ahb_gpio_pkg::GPIO_OFS_ENA)
                            ena_q[g][8*b +: 8] <= i_hwdata[8*b +: 8];
                        if (lanes_q[b] && index_q == ahb_gpio_pkg::GPIO_OFS_DAT)
                            dat_q[g][8*b +: 8] <= i_hwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Group select for readback
    always_comb
    begin
        in_sel  = 32'h0;
        ena_sel = 32'h0;
        dat_sel = 32'h0;
        for (int g = 0; g < NUM_PORTS; g++)
        begin
            if (int'(group_q) == g)
            begin
                in_sel  = i_gpio_in[32*g +: 32];
                ena_sel = ena_q[g];
                dat_sel = dat_q[g];
            end
        end
    end

    always_comb
    begin
        o_hrdata = 32'h0;
        if (rd_q)
        begin
            case (index_q)
                ahb_gpio_pkg::GPIO_OFS_IN:  o_hrdata = in_sel;
                ahb_gpio_pkg::GPIO_OFS_ENA: o_hrdata = ena_sel;
                ahb_gpio_pkg::GPIO_OFS_DAT: o_hrdata = dat_sel;
                default:                    o_hrdata = 32'h0;
            endcase
        end
    end

    for (genvar g = 0; g < NUM_PORTS; g++)
    begin : g_pins
        assign o_gpio_ena[32*g +: 32] = ena_q[g];
        assign o_gpio_dat[32*g +: 32] = dat_q[g];
    end

endmodule

// ==== logic/ahb_sram.sv ====
`timescale 1ns/1ps

module ahb_sram #(
    parameter int SRAM_WORDS = 64
) (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        i_hsel,
    input  logic [31:0] i_haddr,
    input  logic [1:0]  i_htrans,
    input  logic [2:0]  i_hsize,
    input  logic        i_hwrite,
    input  logic [31:0] i_hwdata,
    input  logic        i_hready,
    output logic [31:0] o_hrdata,
    output logic        o_hreadyout
);

    localparam int AW = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

    logic          access;
    logic          wr_q;
    logic          rd_q;
    logic [AW-1:0] word_idx;
    logic [AW-1:0] idx_q;
    logic [3:0]    lanes_q;
    logic [31:0]   mem [SRAM_WORDS];

    assign access      = i_hsel & i_htrans[1] & i_hready;
    assign word_idx    = AW'(i_haddr[31:2] % SRAM_WORDS);
    assign o_hreadyout = 1'b1;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end
        else if (i_hready)
        begin
            wr_q <= access & i_hwrite;
            rd_q <= access & ~i_hwrite;
        end
    end

    // Word index and lanes of the pending transfer
    always_ff @(posedge HCLK)
    begin
        if (access)
        begin
            idx_q   <= word_idx;
            lanes_q <= ahb_gpio_pkg::byte_lanes(i_haddr[1:0], i_hsize);
        end
        if (wr_q && i_hready)
        begin
            for (int b = 0; b < 4; b++)
                if (lanes_q[b])
                    mem[idx_q][8*b +: 8] <= i_hwdata[8*b +: 8];
        end
    end

    assign o_hrdata = rd_q ? mem[idx_q] : 32'h0;

endmodule

// ==== logic/ahb_gpio_subsys.sv ====
`timescale 1ns/1ps

module ahb_gpio_subsys #(
    parameter int NUM_PORTS  = 4,
    parameter int SRAM_WORDS = 64
) (
    input  logic                    HCLK,
    input  logic                    HRESETn,
    input  logic [31:0]             i_haddr,
    input  logic [1:0]              i_htrans,
    input  logic [2:0]              i_hsize,
    input  logic                    i_hwrite,
    input  logic [31:0]             i_hwdata,
    output logic [31:0]             o_hrdata,
    output logic                    o_hready,
    output logic                    o_hresp,
    input  logic [NUM_PORTS*32-1:0] i_gpio_in,
    output logic [NUM_PORTS*32-1:0] o_gpio_ena,
    output logic [NUM_PORTS*32-1:0] o_gpio_dat
);

    logic                    gpio_sel;
    logic                    sram_sel;
    logic [31:0]             gpio_rdata;
    logic [31:0]             sram_rdata;
    logic                    gpio_readyout;
    logic                    sram_readyout;
    logic [NUM_PORTS*32-1:0] gpio_in_sync;

    ahb_decoder u_decoder (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hready(o_hready),
        .i_gpio_rdata(gpio_rdata), .i_gpio_readyout(gpio_readyout),
        .i_sram_rdata(sram_rdata), .i_sram_readyout(sram_readyout),
        .o_gpio_sel(gpio_sel), .o_sram_sel(sram_sel),
        .o_hrdata(o_hrdata), .o_hready(o_hready), .o_hresp(o_hresp)
    );

    gpio_in_sync #(.NUM_PORTS(NUM_PORTS)) u_in_sync (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .i_pins(i_gpio_in), .o_pins_sync(gpio_in_sync)
    );

    ahb_gpio #(.NUM_PORTS(NUM_PORTS)) u_gpio (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .i_hsel(gpio_sel), .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hsize(i_hsize),
        .i_hwrite(i_hwrite), .i_hwdata(i_hwdata), .i_hready(o_hready),
        .i_gpio_in(gpio_in_sync), .o_hrdata(gpio_rdata), .o_hreadyout(gpio_readyout),
        .o_gpio_ena(o_gpio_ena), .o_gpio_dat(o_gpio_dat)
    );

    ahb_sram #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .i_hsel(sram_sel), .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hsize(i_hsize),
        .i_hwrite(i_hwrite), .i_hwdata(i_hwdata), .i_hready(o_hready),
        .o_hrdata(sram_rdata), .o_hreadyout(sram_readyout)
    );

endmodule

// ==== tb/ahb_gpio_subsys_sva.sv ====
`timescale 1ns/1ps

module ahb_gpio_subsys_sva #(
    parameter int NUM_PORTS = 4
) (
    input logic                    HCLK,
    input logic                    HRESETn,
    input logic [31:0]             i_haddr,
    input logic [1:0]              i_htrans,
    input logic                    i_hwrite,
    input logic                    o_hready,
    input logic                    o_hresp,
    input logic [NUM_PORTS*32-1:0] o_gpio_ena,
    input logic [NUM_PORTS*32-1:0] o_gpio_dat
);

    logic gpio_wr_ap;

    // GPIO write address phase accepted
    assign gpio_wr_ap = (i_haddr[31:28] == ahb_gpio_pkg::GPIO_REGION) && i_htrans[1]
                        && i_hwrite && o_hready;

    a_ready_high: assert property (@(posedge HCLK) disable iff (!HRESETn) o_hready)
        else $error("o_hready went low");

    a_resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn) !o_hresp)
        else $error("o_hresp signalled an error");

    a_reset_zero: assert property (@(posedge HCLK)
        !HRESETn && $past(!HRESETn) |-> o_gpio_ena == '0 && o_gpio_dat == '0)
        else $error("GPIO outputs not zero in reset");

    // Pins only move two edges after a GPIO write address phase
    a_pins_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !$past(gpio_wr_ap, 2) |-> $stable(o_gpio_ena) && $stable(o_gpio_dat))
        else $error("GPIO outputs changed without a write");

endmodule

bind ahb_gpio_subsys ahb_gpio_subsys_sva #(.NUM_PORTS(NUM_PORTS)) u_sva (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hwrite(i_hwrite),
    .o_hready(o_hready), .o_hresp(o_hresp),
    .o_gpio_ena(o_gpio_ena), .o_gpio_dat(o_gpio_dat)
);

// ==== tb/ahb_gpio_subsys_tb.sv ====
`timescale 1ns/1ps

module ahb_gpio_subsys_tb;

    localparam int NUM_PORTS = 4;
    localparam int SRAM_WORDS = 64;
    localparam int PW = NUM_PORTS * 32;
    // About twice the total test length
    localparam int TIMEOUT_CYCLES = 3000;

    logic          HCLK;
    logic          HRESETn;
    logic [31:0]   haddr;
    logic [1:0]    htrans;
    logic [2:0]    hsize;
    logic          hwrite;
    logic [31:0]   hwdata;
    logic [PW-1:0] gpio_in;
    logic [31:0]   hrdata;
    logic          hready;
    logic          hresp;
    logic [PW-1:0] gpio_ena;
    logic [PW-1:0] gpio_dat;

    logic [PW-1:0] m_ena;
    logic [PW-1:0] m_dat;
    logic [31:0]   m_sram [SRAM_WORDS];
    logic [31:0]   lfsr = 32'h15b5;
    logic [31:0]   pend_wdata;
    logic [31:0]   a;
    logic [2:0]    sz;
    int            errors = 0;
    int            checks = 0;
    int            tests = 0;
    int            failed_tests = 0;
    int            err_mark = 0;
    int            chk_mark = 0;

    // Address phase, data phase and post-write stages of the expected results
    logic          ap_valid;
    logic          ap_read;
    logic [31:0]   ap_exp;
    logic [PW-1:0] ap_ena;
    logic [PW-1:0] ap_dat;
    logic          dp_valid = 1'b0;
    logic          dp_read = 1'b0;
    logic [31:0]   dp_exp = 32'h0;
    logic [PW-1:0] dp_ena = '0;
    logic [PW-1:0] dp_dat = '0;
    logic          pc_valid = 1'b0;
    logic [PW-1:0] pc_ena = '0;
    logic [PW-1:0] pc_dat = '0;

    ahb_gpio_subsys #(.NUM_PORTS(NUM_PORTS), .SRAM_WORDS(SRAM_WORDS)) uut (
        .HCLK(HCLK), .HRESETn(HRESETn),
        .i_haddr(haddr), .i_htrans(htrans), .i_hsize(hsize), .i_hwrite(hwrite),
        .i_hwdata(hwdata), .o_hrdata(hrdata), .o_hready(hready), .o_hresp(hresp),
        .i_gpio_in(gpio_in), .o_gpio_ena(gpio_ena), .o_gpio_dat(gpio_dat)
    );

    initial
    begin
        HCLK = 1'b0;
        forever
            #5 HCLK = ~HCLK;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [3:0] lane_mask(input logic [1:0] ofs, input logic [2:0] size);
        logic [3:0] lanes;
        lanes = 4'b0000;
        if (size == 3'd0)
            lanes[ofs] = 1'b1;
        else if (size == 3'd1 && !ofs[0])
            lanes = 4'b0011 << ofs;
        else if (size == 3'd2 && ofs == 2'd0)
            lanes = 4'b1111;
        return lanes;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        int g;
        g = int'(addr[7:4]);
        if (addr[31:28] == 4'h2)
            return m_sram[int'(addr[31:2]) % SRAM_WORDS];
        if (addr[31:28] != 4'h4 || g >= NUM_PORTS)
            return 32'h0;
        case (addr[3:2])
            2'd0: return gpio_in[32*g +: 32];
            2'd1: return m_ena[32*g +: 32];
            2'd2: return m_dat[32*g +: 32];
            default: return 32'h0;
        endcase
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [2:0] size,
                                        input logic [31:0] wdata);
        logic [3:0] lanes;
        int         g;
        int         w;
        lanes = lane_mask(addr[1:0], size);
        g = int'(addr[7:4]);
        w = int'(addr[31:2]) % SRAM_WORDS;
        for (int b = 0; b < 4; b++)
        begin
            if (lanes[b] && addr[31:28] == 4'h2)
                m_sram[w][8*b +: 8] = wdata[8*b +: 8];
            else if (lanes[b] && addr[31:28] == 4'h4 && g < NUM_PORTS && addr[3:2] == 2'd1)
                m_ena[32*g + 8*b +: 8] = wdata[8*b +: 8];
            else if (lanes[b] && addr[31:28] == 4'h4 && g < NUM_PORTS && addr[3:2] == 2'd2)
                m_dat[32*g + 8*b +: 8] = wdata[8*b +: 8];
        end
    endfunction

    function automatic logic [31:0] gpio_addr(input logic [3:0] g, input logic [1:0] idx,
                                              input logic [1:0] ofs);
        return {4'h4, 20'h0, g, idx, ofs};
    endfunction

    // Drives one address phase and the write data of the transfer before it
    task automatic xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                        input logic [31:0] wdata);
        @(negedge HCLK);
        hwdata     = pend_wdata;
        haddr      = addr;
        htrans     = 2'b10;
        hsize      = size;
        hwrite     = wr;
        pend_wdata = wr ? wdata : 32'h0;
        ap_valid   = 1'b1;
        ap_read    = !wr;
        ap_exp     = ref_read(addr);
        if (wr)
            model_write(addr, size, wdata);
        ap_ena = m_ena;
        ap_dat = m_dat;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge HCLK);
            hwdata     = pend_wdata;
            htrans     = 2'b00;
            hwrite     = 1'b0;
            pend_wdata = 32'h0;
            ap_valid   = 1'b0;
            ap_read    = 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        idle(3);
        tests++;
        if (errors == err_mark)
            $display("test %s: ok, %0d checks", name, checks - chk_mark);
        else
        begin
            $display("test %s: %0d errors in %0d checks", name, errors - err_mark,
                     checks - chk_mark);
            failed_tests++;
        end
        err_mark = errors;
        chk_mark = checks;
    endtask

    always @(posedge HCLK)
    begin
        if (dp_read)
        begin
            checks++;
            assert (hrdata === dp_exp)
            else
            begin
                $display("FAILED at %0t: o_hrdata expected %h got %h", $time, dp_exp, hrdata);
                errors++;
            end
        end
        // Pins after the data phase has ended
        if (pc_valid)
        begin
            checks++;
            assert (gpio_ena === pc_ena)
            else
            begin
                $display("FAILED at %0t: o_gpio_ena expected %h got %h", $time, pc_ena, gpio_ena);
                errors++;
            end
            assert (gpio_dat === pc_dat)
            else
            begin
                $display("FAILED at %0t: o_gpio_dat expected %h got %h", $time, pc_dat, gpio_dat);
                errors++;
            end
        end
        dp_valid <= ap_valid;
        dp_read  <= ap_read;
        dp_exp   <= ap_exp;
        dp_ena   <= ap_ena;
        dp_dat   <= ap_dat;
        pc_valid <= dp_valid;
        pc_ena   <= dp_ena;
        pc_dat   <= dp_dat;
    end

    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge HCLK);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        HRESETn    = 1'b0;
        haddr      = 32'h0;
        htrans     = 2'b00;
        hsize      = 3'd0;
        hwrite     = 1'b0;
        hwdata     = 32'h0;
        gpio_in    = '0;
        pend_wdata = 32'h0;
        ap_valid   = 1'b0;
        ap_read    = 1'b0;
        ap_exp     = 32'h0;
        m_ena      = '0;
        m_dat      = '0;
        ap_ena     = '0;
        ap_dat     = '0;
        repeat (5) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        for (int g = 0; g < NUM_PORTS; g++)
            for (int r = 0; r < 3; r++)
                xfer(1'b0, gpio_addr(4'(g), 2'(r), 2'd0), 3'd2, 32'h0);
        end_test("reset values");

        for (int g = 0; g < NUM_PORTS; g++)
        begin
            xfer(1'b1, gpio_addr(4'(g), 2'd1, 2'd0), 3'd2, rand_bits(32));
            xfer(1'b0, gpio_addr(4'(g), 2'd1, 2'd0), 3'd2, 32'h0);
            xfer(1'b1, gpio_addr(4'(g), 2'd2, 2'd0), 3'd2, rand_bits(32));
            xfer(1'b0, gpio_addr(4'(g), 2'd2, 2'd0), 3'd2, 32'h0);
        end
        end_test("word writes");

        for (int i = 0; i < 64; i++)
        begin
            a  = gpio_addr(4'(rand_bits(2)), 2'(1 + rand_bits(1)), 2'(rand_bits(2)));
            sz = 3'(rand_bits(2) % 3);
            xfer(1'b1, a, sz, rand_bits(32));
            xfer(1'b0, {a[31:2], 2'b00}, 3'd2, 32'h0);
        end
        end_test("byte lanes");

        for (int i = 0; i < 8; i++)
        begin
            for (int g = 0; g < NUM_PORTS; g++)
                gpio_in[32*g +: 32] = rand_bits(32);
            idle(3);
            for (int g = 0; g < NUM_PORTS; g++)
                xfer(1'b0, gpio_addr(4'(g), 2'd0, 2'd0), 3'd2, 32'h0);
        end
        end_test("pin inputs");

        for (int w = 0; w < SRAM_WORDS; w++)
            xfer(1'b1, {4'h2, 20'h0, 6'(w), 2'b00}, 3'd2, rand_bits(32));
        for (int i = 0; i < 1100; i++)
        begin
            if (rand_bits(1) == 1)
                a = {4'h2, 20'(rand_bits(20)), 6'(rand_bits(6)), 2'(rand_bits(2))};
            else
                a = gpio_addr(4'(rand_bits(2)), 2'(rand_bits(2)), 2'(rand_bits(2)));
            sz = 3'(rand_bits(2) % 3);
            xfer(1'(rand_bits(1)), a, sz, rand_bits(32));
        end
        end_test("sram mix");

        for (int i = 0; i < 8; i++)
        begin
            a = rand_bits(32);
            if (a[31:28] == 4'h2 || a[31:28] == 4'h4)
                a[31:28] = 4'hc;
            xfer(1'b1, a, 3'd2, rand_bits(32));
            xfer(1'b0, a, 3'd2, 32'h0);
            a = gpio_addr(4'(NUM_PORTS + rand_bits(8) % (16 - NUM_PORTS)), 2'(rand_bits(2)), 2'd0);
            xfer(1'b1, a, 3'd2, rand_bits(32));
            xfer(1'b0, a, 3'd2, 32'h0);
            a = gpio_addr(4'(rand_bits(2)), 2'd3, 2'd0);
            xfer(1'b1, a, 3'd2, rand_bits(32));
            xfer(1'b0, a, 3'd2, 32'h0);
        end
        end_test("unmapped");

        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed_tests,
                 checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== ahb_gpio_subsys.f ====
logic/ahb_gpio_pkg.sv
logic/ahb_decoder.sv
logic/gpio_in_sync.sv
logic/ahb_gpio.sv
logic/ahb_sram.sv
logic/ahb_gpio_subsys.sv
tb/ahb_gpio_subsys_sva.sv
tb/ahb_gpio_subsys_tb.sv

// ==== Makefile ====
TOP := ahb_gpio_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f ahb_gpio_subsys.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f ahb_gpio_subsys.f --top-module $(TOP) -o sim
	out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -Fqx '** PASS **'

clean:
	rm -rf obj_dir
